// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_lite_tb
FILELIST  ?= mips_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: core_ctrl.sv
`include "mips_lite_params.svh"
`default_nettype none

module core_ctrl (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [`WORD_W-1:0]            inst_rdata_i,
    input  wire                           inst_addr_ok_i,
    input  wire                           inst_data_ok_i,
    input  wire                           last_i,
    output logic                          inst_req_o,
    output logic [`WORD_W-1:0]            inst_addr_o,
    output logic [`WORD_W-1:0]            pc_o,
    output mips_isa_pkg::inst_u           inst_o,
    output mips_core_pkg::alu_op_e        alu_op_o,
    output logic                          hilo_sel_o,
    output logic                          wb_en_o,
    output logic                          div_start_o,
    output logic                          div_step_o,
    output logic                          div_signed_o,
    output logic                          commit_div_o
);

    mips_core_pkg::ctrl_state_e state;
    logic [`WORD_W-1:0]         pc_q;
    mips_isa_pkg::inst_u        ir;
    mips_core_pkg::alu_op_e     dec_op;
    logic                       dec_hi;
    logic                       dec_div;

    always_comb begin
        dec_op  = mips_core_pkg::ALU_NOP;   // unknown codes retire as no-op
        dec_hi  = 1'b0;
        dec_div = 1'b0;
        case (ir.r_fields.op)
            mips_isa_pkg::OP_SPECIAL: begin
                case (ir.r_fields.funct)
                    mips_isa_pkg::FN_ADDU: dec_op = mips_core_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: dec_op = mips_core_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  dec_op = mips_core_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   dec_op = mips_core_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  dec_op = mips_core_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  dec_op = mips_core_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: dec_op = mips_core_pkg::ALU_SLTU;
                    mips_isa_pkg::FN_MFHI: begin
                        dec_op = mips_core_pkg::ALU_MFHL;
                        dec_hi = 1'b1;
                    end
                    mips_isa_pkg::FN_MFLO: dec_op = mips_core_pkg::ALU_MFHL;
                    mips_isa_pkg::FN_MTHI: begin
                        dec_op = mips_core_pkg::ALU_MTHL;
                        dec_hi = 1'b1;
                    end
                    mips_isa_pkg::FN_MTLO: dec_op = mips_core_pkg::ALU_MTHL;
                    mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU: dec_div = 1'b1;
                    default: ;
                endcase
            end
            mips_isa_pkg::OP_ADDIU: dec_op = mips_core_pkg::ALU_ADD;
            mips_isa_pkg::OP_SLTI:  dec_op = mips_core_pkg::ALU_SLT;
            mips_isa_pkg::OP_ANDI:  dec_op = mips_core_pkg::ALU_AND;
            mips_isa_pkg::OP_ORI:   dec_op = mips_core_pkg::ALU_OR;
            mips_isa_pkg::OP_XORI:  dec_op = mips_core_pkg::ALU_XOR;
            mips_isa_pkg::OP_LUI:   dec_op = mips_core_pkg::ALU_LUI;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= mips_core_pkg::ST_IDLE;
            pc_q       <= `RESET_PC;
            alu_op_o   <= mips_core_pkg::ALU_NOP;
            hilo_sel_o <= 1'b0;
        end else begin
            case (state)
                mips_core_pkg::ST_IDLE: state <= mips_core_pkg::ST_REQ;
                mips_core_pkg::ST_REQ: begin
                    if (inst_addr_ok_i)
                        state <= mips_core_pkg::ST_WAIT;   // request taken
                end
                mips_core_pkg::ST_WAIT: begin
                    if (inst_data_ok_i)
                        state <= mips_core_pkg::ST_DECODE;
                end
                mips_core_pkg::ST_DECODE: begin
                    alu_op_o   <= dec_op;
                    hilo_sel_o <= dec_hi;
                    state      <= dec_div ? mips_core_pkg::ST_DIV : mips_core_pkg::ST_EXEC;
                end
                mips_core_pkg::ST_DIV: begin
                    if (last_i)
                        state <= mips_core_pkg::ST_COMMIT;
                end
                mips_core_pkg::ST_EXEC, mips_core_pkg::ST_COMMIT: begin
                    pc_q  <= pc_q + `WORD_W'(4);  // retire
                    state <= mips_core_pkg::ST_REQ;
                end
                default: state <= mips_core_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips_core_pkg::ST_WAIT && inst_data_ok_i)
            ir <= inst_rdata_i;
    end

    assign inst_req_o   = state == mips_core_pkg::ST_REQ;
    assign inst_addr_o  = pc_q;
    assign pc_o         = pc_q;
    assign inst_o       = ir;
    assign wb_en_o      = state == mips_core_pkg::ST_EXEC;
    assign div_start_o  = state == mips_core_pkg::ST_DECODE && dec_div;
    assign div_step_o   = state == mips_core_pkg::ST_DIV;
    assign div_signed_o = ir.r_fields.funct == mips_isa_pkg::FN_DIV;
    assign commit_div_o = state == mips_core_pkg::ST_COMMIT;

endmodule

`default_nettype wire

// File: div_step_counter.sv
`include "mips_lite_params.svh"
`default_nettype none

module div_step_counter (
    input  wire  clk,
    input  wire  rst,
    input  wire  load_i,
    input  wire  step_i,
    output logic last_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    logic [CNT_W-1:0] cnt;   // steps still to go

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= CNT_W'(`DIV_STEPS);
        end else if (step_i && cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    // high during the final step only
    assign last_o = step_i && cnt == CNT_W'(1);

endmodule

`default_nettype wire

// File: divider.sv
`include "mips_lite_params.svh"
`default_nettype none

module divider (
    input  wire                clk,
    input  wire                rst,
    input  wire                start_i,
    input  wire                step_i,
    input  wire                signed_i,
    input  wire  [`WORD_W-1:0] dividend_i,
    input  wire  [`WORD_W-1:0] divisor_i,
    output logic [`WORD_W-1:0] quotient_o,
    output logic [`WORD_W-1:0] remainder_o
);

    localparam int W = `WORD_W;

    logic [W-1:0] quot_q;   // dividend shifts out, quotient shifts in
    logic [W-1:0] rem_q;
    logic [W-1:0] dvs_q;
    logic         neg_quot;
    logic         neg_rem;
    logic [W-1:0] abs_a;
    logic [W-1:0] abs_b;
    logic [W:0]   partial;
    logic [W:0]   trial;

    assign abs_a = (signed_i && dividend_i[W-1]) ? -dividend_i : dividend_i;
    assign abs_b = (signed_i && divisor_i[W-1]) ? -divisor_i : divisor_i;

    assign partial = {rem_q, quot_q[W-1]};
    assign trial   = partial - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_quot <= 1'b0;
            neg_rem  <= 1'b0;
        end else if (start_i) begin
            neg_quot <= signed_i && (dividend_i[W-1] ^ divisor_i[W-1]);
            neg_rem  <= signed_i && dividend_i[W-1];   // follows the dividend
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quot_q <= abs_a;
            rem_q  <= '0;
            dvs_q  <= abs_b;
        end else if (step_i) begin
            if (trial[W]) begin
                rem_q  <= partial[W-1:0];   // restore
                quot_q <= {quot_q[W-2:0], 1'b0};
            end else begin
                rem_q  <= trial[W-1:0];
                quot_q <= {quot_q[W-2:0], 1'b1};
            end
        end
    end

    // sign fix-up, truncation toward zero
    assign quotient_o  = neg_quot ? -quot_q : quot_q;
    assign remainder_o = neg_rem ? -rem_q : rem_q;

endmodule

`default_nettype wire

// File: exec_datapath.sv
`include "mips_lite_params.svh"
`default_nettype none

module exec_datapath (
    input  wire                           clk,
    input  wire                           rst,
    input  wire mips_isa_pkg::inst_u      inst_i,
    input  wire  [`WORD_W-1:0]            pc_i,
    input  wire mips_core_pkg::alu_op_e   alu_op_i,
    input  wire                           hilo_sel_i,
    input  wire                           wb_en_i,
    input  wire                           commit_div_i,
    input  wire  [`WORD_W-1:0]            quotient_i,
    input  wire  [`WORD_W-1:0]            remainder_i,
    output logic [`WORD_W-1:0]            div_a_o,
    output logic [`WORD_W-1:0]            div_b_o,
    output logic [`WORD_W-1:0]            debug_wb_pc_o,
    output logic [3:0]                    debug_wb_rf_wen_o,
    output logic [`REG_AW-1:0]            debug_wb_rf_wnum_o,
    output logic [`WORD_W-1:0]            debug_wb_rf_wdata_o
);

    localparam int W = `WORD_W;

    logic [W-1:0]       rf [0:(1 << `REG_AW)-1];
    logic [W-1:0]       hi_q;
    logic [W-1:0]       lo_q;
    logic [W-1:0]       rs_val;
    logic [W-1:0]       rt_val;
    logic [W-1:0]       imm_ext;
    logic [W-1:0]       opnd_b;
    logic [W-1:0]       alu_res;
    logic [`REG_AW-1:0] dest;
    logic               is_rtype;
    logic               writes_rf;
    logic               rf_we;

    // register 0 reads as zero
    assign rs_val = (inst_i.r_fields.rs == '0) ? '0 : rf[inst_i.r_fields.rs];
    assign rt_val = (inst_i.r_fields.rt == '0) ? '0 : rf[inst_i.r_fields.rt];

    assign is_rtype = inst_i.r_fields.op == mips_isa_pkg::OP_SPECIAL;

    always_comb begin
        case (inst_i.i_fields.op)
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI:
                imm_ext = {{(W-16){inst_i.i_fields.imm[15]}}, inst_i.i_fields.imm};
            mips_isa_pkg::OP_LUI:
                imm_ext = {inst_i.i_fields.imm, 16'h0000};
            default:
                imm_ext = {{(W-16){1'b0}}, inst_i.i_fields.imm};  // logic ops
        endcase
    end

    assign opnd_b = is_rtype ? rt_val : imm_ext;
    assign dest   = is_rtype ? inst_i.r_fields.rd : inst_i.i_fields.rt;

    always_comb begin
        case (alu_op_i)
            mips_core_pkg::ALU_ADD:  alu_res = rs_val + opnd_b;
            mips_core_pkg::ALU_SUB:  alu_res = rs_val - opnd_b;
            mips_core_pkg::ALU_AND:  alu_res = rs_val & opnd_b;
            mips_core_pkg::ALU_OR:   alu_res = rs_val | opnd_b;
            mips_core_pkg::ALU_XOR:  alu_res = rs_val ^ opnd_b;
            mips_core_pkg::ALU_SLT:  alu_res = W'($signed(rs_val) < $signed(opnd_b));
            mips_core_pkg::ALU_SLTU: alu_res = W'(rs_val < opnd_b);
            mips_core_pkg::ALU_LUI:  alu_res = opnd_b;
            mips_core_pkg::ALU_MFHL: alu_res = hilo_sel_i ? hi_q : lo_q;
            default:                 alu_res = '0;
        endcase
    end

    assign writes_rf = !(alu_op_i inside {mips_core_pkg::ALU_NOP, mips_core_pkg::ALU_MTHL});
    assign rf_we     = wb_en_i && writes_rf && dest != '0;

    always_ff @(posedge clk) begin
        if (commit_div_i) begin
            lo_q <= quotient_i;
            hi_q <= remainder_i;
        end else if (wb_en_i && alu_op_i == mips_core_pkg::ALU_MTHL) begin
            if (hilo_sel_i)
                hi_q <= rs_val;
            else
                lo_q <= rs_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[dest]            <= alu_res;
            debug_wb_pc_o       <= pc_i;
            debug_wb_rf_wnum_o  <= dest;
            debug_wb_rf_wdata_o <= alu_res;
        end
    end

    // one-cycle strobe per committed write
    always_ff @(posedge clk) begin
        if (rst)
            debug_wb_rf_wen_o <= 4'h0;
        else
            debug_wb_rf_wen_o <= rf_we ? 4'hf : 4'h0;
    end

    assign div_a_o = rs_val;
    assign div_b_o = rt_val;

endmodule

`default_nettype wire

// File: mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

    // controller sequence, idle only right after reset
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_DECODE,
        ST_EXEC,
        ST_DIV,
        ST_COMMIT
    } ctrl_state_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_MFHL,   // hi or lo picked by hilo_sel
        ALU_MTHL
    } alu_op_e;

endpackage

`default_nettype wire

// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_MFHI = 6'b010000;
    localparam logic [5:0] FN_MTHI = 6'b010001;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MTLO = 6'b010011;
    localparam logic [5:0] FN_DIV  = 6'b011010;
    localparam logic [5:0] FN_DIVU = 6'b011011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // one fetched word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fields;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fields;
    } inst_u;

endpackage

`default_nettype wire

// File: mips_lite.f
+incdir+.
mips_isa_pkg.sv
mips_core_pkg.sv
div_step_counter.sv
divider.sv
exec_datapath.sv
core_ctrl.sv
mips_lite.sv
mips_lite_chk.sv
mips_lite_tb.sv

// File: mips_lite.sv
`include "mips_lite_params.svh"
`default_nettype none

module mips_lite (
    input  wire                clk,
    input  wire                rst,

    // inst sram-like, read only
    output logic               inst_req_o,
    output logic [`WORD_W-1:0] inst_addr_o,
    input  wire  [`WORD_W-1:0] inst_rdata_i,
    input  wire                inst_addr_ok_i,
    input  wire                inst_data_ok_i,

    // debug writeback
    output logic [`WORD_W-1:0] debug_wb_pc_o,
    output logic [3:0]         debug_wb_rf_wen_o,
    output logic [`REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [`WORD_W-1:0] debug_wb_rf_wdata_o
);

    logic [`WORD_W-1:0]      pc;
    mips_isa_pkg::inst_u     inst;
    mips_core_pkg::alu_op_e  alu_op;
    logic                    hilo_sel;
    logic                    wb_en;
    logic                    div_start;
    logic                    div_step;
    logic                    div_signed;
    logic                    commit_div;
    logic                    div_last;
    logic [`WORD_W-1:0]      div_a;
    logic [`WORD_W-1:0]      div_b;
    logic [`WORD_W-1:0]      quotient;
    logic [`WORD_W-1:0]      remainder;

    core_ctrl ctrl0 (
        .clk(clk), .rst(rst),
        .inst_rdata_i(inst_rdata_i), .inst_addr_ok_i(inst_addr_ok_i),
        .inst_data_ok_i(inst_data_ok_i), .last_i(div_last),
        .inst_req_o(inst_req_o), .inst_addr_o(inst_addr_o), .pc_o(pc),
        .inst_o(inst), .alu_op_o(alu_op), .hilo_sel_o(hilo_sel), .wb_en_o(wb_en),
        .div_start_o(div_start), .div_step_o(div_step), .div_signed_o(div_signed),
        .commit_div_o(commit_div)
    );

    exec_datapath exec0 (
        .clk(clk), .rst(rst),
        .inst_i(inst), .pc_i(pc), .alu_op_i(alu_op), .hilo_sel_i(hilo_sel),
        .wb_en_i(wb_en), .commit_div_i(commit_div),
        .quotient_i(quotient), .remainder_i(remainder),
        .div_a_o(div_a), .div_b_o(div_b),
        .debug_wb_pc_o(debug_wb_pc_o), .debug_wb_rf_wen_o(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o), .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    divider div0 (
        .clk(clk), .rst(rst),
        .start_i(div_start), .step_i(div_step), .signed_i(div_signed),
        .dividend_i(div_a), .divisor_i(div_b),
        .quotient_o(quotient), .remainder_o(remainder)
    );

    div_step_counter step_cnt0 (
        .clk(clk), .rst(rst),
        .load_i(div_start), .step_i(div_step),
        .last_o(div_last)
    );

endmodule

`default_nettype wire

// File: mips_lite_chk.sv
`include "mips_lite_params.svh"
`default_nettype none

module mips_lite_chk (
    input wire                         clk,
    input wire                         rst,
    input wire                         req_i,
    input wire [`WORD_W-1:0]           addr_i,
    input wire                         addr_ok_i,
    input wire                         data_ok_i,
    input wire [3:0]                   wen_i,
    input wire [`REG_AW-1:0]           wnum_i,
    input wire mips_core_pkg::ctrl_state_e state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       first_fetch;   // nothing accepted since reset
    logic       pending;       // accepted, word not back yet
    logic [7:0] div_cycles;    // consecutive divide step cycles

    always_ff @(posedge clk) begin
        if (rst) begin
            first_fetch <= 1'b1;
            pending     <= 1'b0;
        end else if (req_i && addr_ok_i) begin
            first_fetch <= 1'b0;
            pending     <= 1'b1;
        end else if (data_ok_i) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            div_cycles <= '0;
        else if (state_i == mips_core_pkg::ST_DIV)
            div_cycles <= div_cycles + 8'd1;
        else
            div_cycles <= '0;
    end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !req_i && wen_i == 4'h0)
        else $error("fetch or writeback active right after reset");
    a_boot_addr: assert property (@(posedge clk) disable iff (rst)
        first_fetch && req_i && addr_ok_i |-> addr_i == `RESET_PC)
        else $error("first fetch not at the boot address");
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_i && !addr_ok_i |=> req_i && $stable(addr_i))
        else $error("request or address changed before acceptance");
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        req_i && addr_ok_i |=> !req_i)
        else $error("request still high after acceptance");
    a_one_pending: assert property (@(posedge clk) disable iff (rst) pending |-> !req_i)
        else $error("new request while a fetch is outstanding");
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        wen_i != 4'h0 |-> wnum_i != '0)
        else $error("write strobe for register 0");
    a_wen_pulse: assert property (@(posedge clk) disable iff (rst)
        wen_i != 4'h0 |=> wen_i == 4'h0)
        else $error("write strobe longer than one cycle");
    // divide leaves its step state after exactly DIV_STEPS cycles
    a_div_len: assert property (@(posedge clk) disable iff (rst)
        div_cycles != '0 && state_i != mips_core_pkg::ST_DIV |-> div_cycles == `DIV_STEPS)
        else $error("divide did not run for the expected number of steps");

endmodule

bind mips_lite mips_lite_chk chk0 (
    .clk(clk), .rst(rst),
    .req_i(inst_req_o), .addr_i(inst_addr_o),
    .addr_ok_i(inst_addr_ok_i), .data_ok_i(inst_data_ok_i),
    .wen_i(debug_wb_rf_wen_o), .wnum_i(debug_wb_rf_wnum_o),
    .state_i(ctrl0.state)
);

`default_nettype wire

// File: mips_lite_params.svh
`ifndef MIPS_LITE_PARAMS_SVH
`define MIPS_LITE_PARAMS_SVH

`default_nettype none

// datapath word and register file address
`define WORD_W 32
`define REG_AW 5

// first fetch address, boot region
`define RESET_PC 32'hbfc00000

// one quotient bit per step
`define DIV_STEPS 32

`default_nettype wire

`endif

// File: mips_lite_tb.sv
`include "mips_lite_params.svh"
`default_nettype none

module mips_lite_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_INST    = 400;
    localparam int          TIMEOUT   = 200;   // cycles, longer than any divide
    localparam logic [31:0] LFSR_MASK = 32'h80200003;

    logic                clk = 1'b0;
    logic                rst;
    logic                inst_req;
    logic [`WORD_W-1:0]  inst_addr;
    logic [`WORD_W-1:0]  inst_rdata;
    logic                addr_ok;
    logic                data_ok;
    logic [`WORD_W-1:0]  wb_pc;
    logic [3:0]          wb_wen;
    logic [`REG_AW-1:0]  wb_wnum;
    logic [`WORD_W-1:0]  wb_wdata;

    logic [31:0] lfsr = 32'h92d0;
    logic [31:0] regs [0:31];   // reference register file
    logic [31:0] hi;
    logic [31:0] lo;
    logic        hi_set;
    logic        lo_set;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic        failed = 1'b0;
    logic        done = 1'b0;

    mips_lite uut (
        .clk(clk), .rst(rst),
        .inst_req_o(inst_req), .inst_addr_o(inst_addr), .inst_rdata_i(inst_rdata),
        .inst_addr_ok_i(addr_ok), .inst_data_ok_i(data_ok),
        .debug_wb_pc_o(wb_pc), .debug_wb_rf_wen_o(wb_wen),
        .debug_wb_rf_wnum_o(wb_wnum), .debug_wb_rf_wdata_o(wb_wdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_MASK : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("error %s got %h expected %h", name, got, want);
        $display("=== FAIL ===");
        failed = 1'b1;
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        failed = 1'b1;
        $fatal(1, "run aborted");
    endtask

    function automatic mips_isa_pkg::inst_u draw_inst(input int idx);
        mips_isa_pkg::inst_u w;
        logic [3:0]          kind;
        w = '0;
        w.r_fields.rs = 5'(take_bits(5));
        w.r_fields.rt = 5'(take_bits(5));
        w.r_fields.rd = 5'(take_bits(5));
        if (idx < 31) begin
            // every register gets a known value first
            w.i_fields.op  = idx[0] ? mips_isa_pkg::OP_LUI : mips_isa_pkg::OP_ORI;
            w.i_fields.rs  = '0;
            w.i_fields.rt  = 5'(idx + 1);
            w.i_fields.imm = 16'(take_bits(16));
            return w;
        end
        kind = 4'(take_bits(4));
        if (kind >= 4'd7 && kind <= 4'd12) begin
            w.i_fields.imm = 16'(take_bits(16));
            case (kind)
                4'd7:    w.i_fields.op = mips_isa_pkg::OP_ADDIU;
                4'd8:    w.i_fields.op = mips_isa_pkg::OP_SLTI;
                4'd9:    w.i_fields.op = mips_isa_pkg::OP_ANDI;
                4'd10:   w.i_fields.op = mips_isa_pkg::OP_ORI;
                4'd11:   w.i_fields.op = mips_isa_pkg::OP_XORI;
                default: begin
                    w.i_fields.op = mips_isa_pkg::OP_LUI;
                    w.i_fields.rs = '0;
                end
            endcase
        end else begin
            case (kind)
                4'd0: w.r_fields.funct = mips_isa_pkg::FN_ADDU;
                4'd1: w.r_fields.funct = mips_isa_pkg::FN_SUBU;
                4'd2: w.r_fields.funct = mips_isa_pkg::FN_AND;
                4'd3: w.r_fields.funct = mips_isa_pkg::FN_OR;
                4'd4: w.r_fields.funct = mips_isa_pkg::FN_XOR;
                4'd5: w.r_fields.funct = mips_isa_pkg::FN_SLT;
                4'd6: w.r_fields.funct = mips_isa_pkg::FN_SLTU;
                4'd13: begin
                    // read back only what was written, else write it now
                    if (take_bits(1) != 0)
                        w.r_fields.funct = hi_set ? mips_isa_pkg::FN_MFHI
                                                  : mips_isa_pkg::FN_MTHI;
                    else
                        w.r_fields.funct = lo_set ? mips_isa_pkg::FN_MFLO
                                                  : mips_isa_pkg::FN_MTLO;
                end
                4'd14: w.r_fields.funct = (take_bits(1) != 0) ? mips_isa_pkg::FN_MTHI
                                                               : mips_isa_pkg::FN_MTLO;
                default: begin
                    if (w.r_fields.rt == '0)
                        w.r_fields.rt = 5'd1;
                    w.r_fields.funct = (take_bits(1) != 0) ? mips_isa_pkg::FN_DIV
                                                            : mips_isa_pkg::FN_DIVU;
                    if (regs[w.r_fields.rt] == '0) begin
                        w.i_fields.op  = mips_isa_pkg::OP_ORI;   // load divisor instead
                        w.i_fields.rs  = '0;
                        w.i_fields.imm = 16'(take_bits(16)) | 16'h1;
                    end
                end
            endcase
        end
        return w;
    endfunction

    task automatic run_model(input mips_isa_pkg::inst_u w, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [4:0]  dst;
        logic        wr;
        logic        neg_a;
        logic        neg_b;
        a    = regs[w.r_fields.rs];
        b    = regs[w.r_fields.rt];
        sext = {{16{w.i_fields.imm[15]}}, w.i_fields.imm};
        zext = {16'h0000, w.i_fields.imm};
        res  = '0;
        wr   = 1'b1;
        dst  = w.r_fields.rd;
        if (w.r_fields.op == mips_isa_pkg::OP_SPECIAL) begin
            case (w.r_fields.funct)
                mips_isa_pkg::FN_ADDU: res = a + b;
                mips_isa_pkg::FN_SUBU: res = a - b;
                mips_isa_pkg::FN_AND:  res = a & b;
                mips_isa_pkg::FN_OR:   res = a | b;
                mips_isa_pkg::FN_XOR:  res = a ^ b;
                mips_isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_isa_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                mips_isa_pkg::FN_MFHI: res = hi;
                mips_isa_pkg::FN_MFLO: res = lo;
                mips_isa_pkg::FN_MTHI: begin
                    hi     = a;
                    hi_set = 1'b1;
                    wr     = 1'b0;
                end
                mips_isa_pkg::FN_MTLO: begin
                    lo     = a;
                    lo_set = 1'b1;
                    wr     = 1'b0;
                end
                mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU: begin
                    // magnitudes, then quotient toward zero, remainder like dividend
                    neg_a  = w.r_fields.funct == mips_isa_pkg::FN_DIV && a[31];
                    neg_b  = w.r_fields.funct == mips_isa_pkg::FN_DIV && b[31];
                    ma     = neg_a ? -a : a;
                    mb     = neg_b ? -b : b;
                    lo     = (neg_a ^ neg_b) ? -(ma / mb) : ma / mb;
                    hi     = neg_a ? -(ma % mb) : ma % mb;
                    hi_set = 1'b1;
                    lo_set = 1'b1;
                    wr     = 1'b0;
                end
                default: wr = 1'b0;
            endcase
        end else begin
            dst = w.i_fields.rt;
            case (w.i_fields.op)
                mips_isa_pkg::OP_ADDIU: res = a + sext;
                mips_isa_pkg::OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                mips_isa_pkg::OP_ANDI:  res = a & zext;
                mips_isa_pkg::OP_ORI:   res = a | zext;
                mips_isa_pkg::OP_XORI:  res = a ^ zext;
                mips_isa_pkg::OP_LUI:   res = {w.i_fields.imm, 16'h0000};
                default:                wr = 1'b0;
            endcase
        end
        if (wr && dst != '0) begin   // r0 never written
            regs[dst] = res;
            exp_pc.push_back(pc);
            exp_num.push_back(dst);
            exp_data.push_back(res);
        end
    endtask

    task automatic check_write();
        assert (exp_pc.size() != 0)
            else abort_run("register write seen with no instruction expecting one");
        assert (wb_wen == 4'hf) else report_mismatch("debug_wb_rf_wen", 32'(wb_wen), 32'hf);
        assert (wb_pc == exp_pc[0]) else report_mismatch("debug_wb_pc", wb_pc, exp_pc[0]);
        assert (wb_wnum == exp_num[0])
            else report_mismatch("debug_wb_rf_wnum", 32'(wb_wnum), 32'(exp_num[0]));
        assert (wb_wdata == exp_data[0])
            else report_mismatch("debug_wb_rf_wdata", wb_wdata, exp_data[0]);
        void'(exp_pc.pop_front());
        void'(exp_num.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic wait_request();
        int n;
        n = 0;
        while (!inst_req) begin
            if (n == TIMEOUT)
                abort_run("timeout waiting for a fetch request");
            n++;
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb_wen != 4'h0)
            check_write();
    end

    initial begin
        mips_isa_pkg::inst_u w;
        logic [31:0]         pc;
        int                  d;
        int                  k;
        int                  idx;
        rst        = 1'b1;
        addr_ok    = 1'b0;
        data_ok    = 1'b0;
        inst_rdata = '0;
        hi_set     = 1'b0;
        lo_set     = 1'b0;
        for (k = 0; k < 32; k++)
            regs[k] = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        pc  = `RESET_PC;
        for (idx = 0; idx < N_INST; idx++) begin
            wait_request();
            d = take_bits(2);   // address phase stall
            for (k = 0; k <= d; k++) begin
                if (k != 0)
                    @(negedge clk);
                assert (inst_req) else abort_run("fetch request dropped before acceptance");
                assert (inst_addr == pc) else report_mismatch("inst_addr", inst_addr, pc);
            end
            addr_ok = 1'b1;
            @(negedge clk);
            addr_ok = 1'b0;
            d = take_bits(2);   // data phase stall
            for (k = 0; k <= d; k++) begin
                if (k != 0)
                    @(negedge clk);
                assert (!inst_req) else abort_run("second fetch request while one is pending");
            end
            w = draw_inst(idx);
            run_model(w, pc);
            inst_rdata = w;
            data_ok    = 1'b1;
            @(negedge clk);
            data_ok = 1'b0;
            pc      = pc + 32'd4;
        end
        wait_request();   // last instruction retired
        @(negedge clk);
        if (exp_pc.size() == 0) begin
            done = 1'b1;
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("expected register writes never appeared");
        end
    end

    // run ended early by a bound assertion
    final begin
        if (!done && !failed)
            $display("=== FAIL ===");
    end

endmodule

`default_nettype wire
